/* Makefile */
# Verilator build and run of the AXI SRAM bridge testbench

SRCS := $(shell cat tb.f)
BIN  := obj_dir/Vaxi_sram_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module axi_sram_tb -f tb.f

run: $(BIN)
	$(BIN) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/axi_sram_fsm.sv */
`timescale 1ns/100ps

module axi_sram_fsm (
   input  logic aclk,
   input  logic reset,
   input  logic arvalid,
   input  logic rready,
   input  logic awvalid,
   input  logic wvalid,
   input  logic bready,
   input  logic rd_done,
   output logic arready,
   output logic awready,
   output logic wready,
   output logic rvalid,
   output logic bvalid,
   output logic ar_take,
   output logic aw_take,
   output logic w_take,
   output logic rd_start,
   output logic ram_rd_en,
   output logic ram_wr_en
);

   import axi_sram_pkg::*;

   bridge_state_t state;
   bridge_state_t state_nxt;

   // aw / w beats captured for the pending write
   logic aw_got;
   logic w_got;
   logic wr_ready_state;
   logic r_retire;
   logic b_retire;

   // write channels open only while collecting a write
   assign wr_ready_state = (state == ST_IDLE) || (state == ST_WR_COLLECT);
   assign awready        = wr_ready_state & ~aw_got;
   assign wready         = wr_ready_state & ~w_got;

   // writes win in idle, a read waits until both write valids are low
   assign arready = (state == ST_IDLE) & ~awvalid & ~wvalid;

   assign rvalid = (state == ST_RD_RESP);
   assign bvalid = (state == ST_WR_RESP);

   // channel handshakes
   assign ar_take  = arvalid & arready;
   assign aw_take  = awvalid & awready;
   assign w_take   = wvalid & wready;
   assign r_retire = rvalid & rready;
   assign b_retire = bvalid & bready;

   // sram read issued with the AR handshake, timer started alongside
   assign ram_rd_en = ar_take;
   assign rd_start  = ar_take;

   // single write once both halves are held
   assign ram_wr_en = (state == ST_WR_COLLECT) & aw_got & w_got;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (ar_take) begin
               state_nxt = ST_RD_WAIT;
            end else if (aw_take || w_take) begin
               state_nxt = ST_WR_COLLECT;
            end
         end
         ST_WR_COLLECT: begin
            // memory write happens in this cycle
            if (aw_got && w_got) begin
               state_nxt = ST_WR_RESP;
            end
         end
         ST_WR_RESP: begin
            if (b_retire) begin
               state_nxt = ST_IDLE;
            end
         end
         ST_RD_WAIT: begin
            if (rd_done) begin
               state_nxt = ST_RD_RESP;
            end
         end
         ST_RD_RESP: begin
            if (r_retire) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge aclk) begin
      if (reset) begin
         state  <= ST_IDLE;
         aw_got <= 1'b0;
         w_got  <= 1'b0;
      end else begin
         state <= state_nxt;
         // B handshake frees both write channels
         if (b_retire) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
         end else begin
            if (aw_take) begin
               aw_got <= 1'b1;
            end
            if (w_take) begin
               w_got <= 1'b1;
            end
         end
      end
   end

endmodule

/* hdl/axi_sram_pkg.sv */
package axi_sram_pkg;

   // plain vector widths
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   typedef logic [4:0]  id_t;
   typedef logic [1:0]  resp_t;

   // word index into the sram, low bits used by the array
   typedef logic [15:0] widx_t;

   // only OKAY is ever returned
   localparam resp_t RESP_OKAY = 2'b00;

   // read address channel payload
   typedef struct packed {
      id_t   id;
      addr_t addr;
   } ar_req_t;

   // write address channel payload
   typedef struct packed {
      id_t   id;
      addr_t addr;
   } aw_req_t;

   // write data beat, id kept for port compatibility
   typedef struct packed {
      id_t   id;
      data_t data;
      strb_t strb;
   } w_beat_t;

   // read data beat
   typedef struct packed {
      id_t   id;
      data_t data;
      resp_t resp;
   } r_beat_t;

   // write response
   typedef struct packed {
      id_t   id;
      resp_t resp;
   } b_beat_t;

   // one sram write, index + data + byte enables
   typedef struct packed {
      widx_t idx;
      data_t data;
      strb_t strb;
   } ram_wr_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_COLLECT,
      ST_WR_RESP,
      ST_RD_WAIT,
      ST_RD_RESP
   } bridge_state_t;

endpackage

/* hdl/axi_sram_req_regs.sv */
`timescale 1ns/100ps

module axi_sram_req_regs (
   input  logic                  aclk,
   input  logic                  reset,
   input  axi_sram_pkg::ar_req_t ar,
   input  axi_sram_pkg::aw_req_t aw,
   input  axi_sram_pkg::w_beat_t w,
   input  logic                  ar_take,
   input  logic                  aw_take,
   input  logic                  w_take,
   input  logic                  rd_done,
   input  axi_sram_pkg::data_t   ram_rdata,
   output axi_sram_pkg::addr_t   ram_raddr,
   output axi_sram_pkg::ram_wr_t ram_wr,
   output axi_sram_pkg::r_beat_t r,
   output axi_sram_pkg::b_beat_t b
);

   import axi_sram_pkg::*;

   // read request
   id_t   ar_id_q;
   addr_t ar_addr_q;

   // write address
   id_t   aw_id_q;
   addr_t aw_addr_q;

   // write beat, W id dropped as in AXI4
   data_t w_data_q;
   strb_t w_strb_q;

   // returned word, held while rready is low
   data_t rdata_q;

   // address live in the take cycle, held value otherwise
   assign ram_raddr = ar_take ? ar.addr : ar_addr_q;

   // word index from byte address
   assign ram_wr.idx  = aw_addr_q[$bits(widx_t)+1:2];
   assign ram_wr.data = w_data_q;
   assign ram_wr.strb = w_strb_q;

   assign r.id   = ar_id_q;
   assign r.data = rdata_q;
   assign r.resp = RESP_OKAY;

   // response id follows the aw beat
   assign b.id   = aw_id_q;
   assign b.resp = RESP_OKAY;

   // ids cleared so idle responses show id 0
   always_ff @(posedge aclk) begin
      if (reset) begin
         ar_id_q <= '0;
         aw_id_q <= '0;
      end else begin
         if (ar_take) begin
            ar_id_q <= ar.id;
         end
         if (aw_take) begin
            aw_id_q <= aw.id;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (ar_take) begin
         ar_addr_q <= ar.addr;
      end
      if (aw_take) begin
         aw_addr_q <= aw.addr;
      end
      if (w_take) begin
         w_data_q <= w.data;
         w_strb_q <= w.strb;
      end
      // memory output valid by the done cycle
      if (rd_done) begin
         rdata_q <= ram_rdata;
      end
   end

endmodule

/* hdl/axi_sram_top.sv */
`timescale 1ns/100ps

module axi_sram_top #(
   parameter int READ_LATENCY = 1,
   parameter int MEM_WORDS    = 1024
) (
   input  logic                  aclk,
   input  logic                  reset,
   // read address
   input  axi_sram_pkg::ar_req_t ar,
   input  logic                  arvalid,
   output logic                  arready,
   // read data
   output axi_sram_pkg::r_beat_t r,
   output logic                  rlast,
   output logic                  rvalid,
   input  logic                  rready,
   // write address
   input  axi_sram_pkg::aw_req_t aw,
   input  logic                  awvalid,
   output logic                  awready,
   // write data
   input  axi_sram_pkg::w_beat_t w,
   input  logic                  wlast,
   input  logic                  wvalid,
   output logic                  wready,
   // write response
   output axi_sram_pkg::b_beat_t b,
   output logic                  bvalid,
   input  logic                  bready
);

   import axi_sram_pkg::*;

   // handshake strobes from the fsm
   logic ar_take;
   logic aw_take;
   logic w_take;

   // read timing
   logic rd_start;
   logic rd_done;

   // sram side
   logic    ram_rd_en;
   logic    ram_wr_en;
   addr_t   ram_raddr;
   ram_wr_t ram_wr;
   data_t   ram_rdata;

   // single beat only, every R is the last
   assign rlast = 1'b1;

   axi_sram_fsm axi_sram_fsm_i (
      .aclk      (aclk),
      .reset     (reset),
      .arvalid   (arvalid),
      .rready    (rready),
      .awvalid   (awvalid),
      .wvalid    (wvalid & wlast),
      .bready    (bready),
      .rd_done   (rd_done),
      .arready   (arready),
      .awready   (awready),
      .wready    (wready),
      .rvalid    (rvalid),
      .bvalid    (bvalid),
      .ar_take   (ar_take),
      .aw_take   (aw_take),
      .w_take    (w_take),
      .rd_start  (rd_start),
      .ram_rd_en (ram_rd_en),
      .ram_wr_en (ram_wr_en)
   );

   axi_sram_wait_timer #(
      .READ_LATENCY (READ_LATENCY)
   ) axi_sram_wait_timer_i (
      .aclk     (aclk),
      .reset    (reset),
      .rd_start (rd_start),
      .rd_done  (rd_done)
   );

   axi_sram_req_regs axi_sram_req_regs_i (
      .aclk      (aclk),
      .reset     (reset),
      .ar        (ar),
      .aw        (aw),
      .w         (w),
      .ar_take   (ar_take),
      .aw_take   (aw_take),
      .w_take    (w_take),
      .rd_done   (rd_done),
      .ram_rdata (ram_rdata),
      .ram_raddr (ram_raddr),
      .ram_wr    (ram_wr),
      .r         (r),
      .b         (b)
   );

   sram_array #(
      .READ_LATENCY (READ_LATENCY),
      .MEM_WORDS    (MEM_WORDS)
   ) sram_array_i (
      .aclk      (aclk),
      .ram_rd_en (ram_rd_en),
      .ram_raddr (ram_raddr),
      .ram_wr_en (ram_wr_en),
      .ram_wr    (ram_wr),
      .ram_rdata (ram_rdata)
   );

endmodule

/* hdl/axi_sram_wait_timer.sv */
`timescale 1ns/100ps

module axi_sram_wait_timer #(
   parameter int READ_LATENCY = 1
) (
   input  logic aclk,
   input  logic reset,
   input  logic rd_start,
   output logic rd_done
);

   // wide enough to hold the latency value itself
   localparam int CNT_W = $clog2(READ_LATENCY + 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge aclk) begin
      if (reset) begin
         cnt     <= '0;
         rd_done <= 1'b0;
      end else begin
         // last counting cycle turns into the done pulse
         rd_done <= (cnt == CNT_W'(1));
         if (rd_start) begin
            cnt <= CNT_W'(READ_LATENCY);
         end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
         end
      end
   end

endmodule

/* hdl/sram_array.sv */
`timescale 1ns/100ps

module sram_array #(
   parameter int READ_LATENCY = 1,
   parameter int MEM_WORDS    = 1024
) (
   input  logic                  aclk,
   input  logic                  ram_rd_en,
   input  axi_sram_pkg::addr_t   ram_raddr,
   input  logic                  ram_wr_en,
   input  axi_sram_pkg::ram_wr_t ram_wr,
   output axi_sram_pkg::data_t   ram_rdata
);

   import axi_sram_pkg::*;

   // index bits, depth is a power of two
   localparam int IDX_W = $clog2(MEM_WORDS);
   localparam int NBYTE = $bits(strb_t);

   data_t mem [MEM_WORDS];

   // stage 0 is the registered read, the rest just delay it
   data_t rd_pipe [READ_LATENCY];

   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;

   // modulo MEM_WORDS by dropping upper bits
   assign rd_idx = ram_raddr[IDX_W+1:2];
   assign wr_idx = ram_wr.idx[IDX_W-1:0];

   // byte-strobed write
   always_ff @(posedge aclk) begin
      if (ram_wr_en) begin
         for (int i = 0; i < NBYTE; i++) begin
            if (ram_wr.strb[i]) begin
               mem[wr_idx][8*i +: 8] <= ram_wr.data[8*i +: 8];
            end
         end
      end
   end

   // read port plus delay stages
   always_ff @(posedge aclk) begin
      if (ram_rd_en) begin
         rd_pipe[0] <= mem[rd_idx];
      end
      for (int s = 1; s < READ_LATENCY; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign ram_rdata = rd_pipe[READ_LATENCY-1];

endmodule

/* tb.f */
hdl/axi_sram_pkg.sv
hdl/axi_sram_fsm.sv
hdl/axi_sram_wait_timer.sv
hdl/axi_sram_req_regs.sv
hdl/sram_array.sv
hdl/axi_sram_top.sv
verif/axi_sram_chk.sv
verif/axi_sram_monitor.sv
verif/axi_sram_tb.sv

/* verif/axi_sram_chk.sv */
`timescale 1ns/100ps

module axi_sram_chk (
   input logic                  aclk,
   input logic                  reset,
   input logic                  arready,
   input logic                  awready,
   input logic                  wready,
   input axi_sram_pkg::r_beat_t r,
   input logic                  rvalid,
   input logic                  rready,
   input axi_sram_pkg::b_beat_t b,
   input logic                  bvalid,
   input logic                  bready
);

   // count of assertion failures
   int unsigned fail_count = 0;

   // write channels open and no response pending after a reset edge
   reset_idle: assert property (@(posedge aclk)
      reset |=> awready && wready && !rvalid && !bvalid)
      else begin
         fail_count++;
         $error("bridge not idle after reset");
      end

   // R held under back-pressure
   r_hold: assert property (@(posedge aclk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(r))
      else begin
         fail_count++;
         $error("R beat dropped or changed while rready was low");
      end

   b_hold: assert property (@(posedge aclk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(b))
      else begin
         fail_count++;
         $error("B beat dropped or changed while bready was low");
      end

   // request channels closed while a response waits
   busy_closed: assert property (@(posedge aclk) disable iff (reset)
      (rvalid || bvalid) |-> !arready && !awready && !wready)
      else begin
         fail_count++;
         $error("request channel ready while a response was pending");
      end

endmodule

bind axi_sram_top axi_sram_chk axi_sram_chk_i (
   .aclk    (aclk),
   .reset   (reset),
   .arready (arready),
   .awready (awready),
   .wready  (wready),
   .r       (r),
   .rvalid  (rvalid),
   .rready  (rready),
   .b       (b),
   .bvalid  (bvalid),
   .bready  (bready)
);

/* verif/axi_sram_monitor.sv */
`timescale 1ns/100ps

module axi_sram_monitor #(
   parameter int READ_LATENCY = 1,
   parameter int MEM_WORDS    = 1024
) (
   input  logic                  aclk,
   input  logic                  reset,
   input  axi_sram_pkg::ar_req_t ar,
   input  logic                  arvalid,
   input  logic                  arready,
   input  axi_sram_pkg::r_beat_t r,
   input  logic                  rlast,
   input  logic                  rvalid,
   input  logic                  rready,
   input  axi_sram_pkg::aw_req_t aw,
   input  logic                  awvalid,
   input  logic                  awready,
   input  axi_sram_pkg::w_beat_t w,
   input  logic                  wvalid,
   input  logic                  wready,
   input  axi_sram_pkg::b_beat_t b,
   input  logic                  bvalid,
   input  logic                  bready,
   output int unsigned           value_errors,
   output int unsigned           proto_errors
);

   import axi_sram_pkg::*;

   // shadow of the sram and which bytes were ever written
   data_t shadow [MEM_WORDS];
   strb_t known [MEM_WORDS];

   logic        rst_seen = 1'b0;
   // open read as seen on the ports
   logic        rd_pend;
   logic        rd_rose;
   int          rd_edges;
   id_t         rd_id;
   addr_t       rd_addr;
   // captured write halves
   logic        aw_got;
   logic        w_got;
   id_t         aw_id;
   addr_t       aw_addr;
   data_t       w_data;
   strb_t       w_strb;
   int unsigned idx;
   data_t       mask;

   function automatic int unsigned word_of(addr_t a);
      return (a >> 2) % MEM_WORDS;
   endfunction

   task automatic check_hex(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic proto_fail(string msg);
      $display("protocol error: %s", msg);
      proto_errors++;
   endtask

   always @(posedge aclk) begin
      if (reset) begin
         // second reset edge sees the state left by the first
         if (rst_seen) begin
            check_hex("arready", 32'h1, 32'(arready));
            check_hex("awready", 32'h1, 32'(awready));
            check_hex("wready", 32'h1, 32'(wready));
            check_hex("rvalid", 32'h0, 32'(rvalid));
            check_hex("bvalid", 32'h0, 32'(bvalid));
         end else begin
            value_errors = 0;
            proto_errors = 0;
         end
         rst_seen = 1'b1;
         rd_pend  = 1'b0;
         aw_got   = 1'b0;
         w_got    = 1'b0;
         foreach (known[i]) known[i] = '0;
      end else begin
         // nothing new while a transaction is open
         if (arvalid && arready && (rd_pend || aw_got || w_got)) begin
            proto_fail("read accepted while another transaction was still open");
         end
         if (awvalid && awready && (rd_pend || aw_got)) begin
            proto_fail("write address accepted while a transaction was still open");
         end
         if (wvalid && wready && (rd_pend || w_got)) begin
            proto_fail("write data accepted while a transaction was still open");
         end
         // a response only while its own request is open
         if (rvalid && !rd_pend) begin
            proto_fail("R valid with no read outstanding");
         end
         if (bvalid && !(aw_got && w_got)) begin
            proto_fail("B valid with no complete write outstanding");
         end
         // edges from AR handshake to the rise of rvalid
         if (rd_pend && !rd_rose) begin
            rd_edges++;
            if (rvalid) begin
               rd_rose = 1'b1;
               check_hex("rvalid_delay", 32'(READ_LATENCY + 1), 32'(rd_edges - 1));
            end
         end
         if (rvalid && rready) begin
            if (rd_pend) begin
               idx = word_of(rd_addr);
               // never written bytes are not compared
               for (int i = 0; i < 4; i++) begin
                  mask[8*i +: 8] = {8{known[idx][i]}};
               end
               check_hex("rid", 32'(rd_id), 32'(r.id));
               check_hex("rresp", 32'(RESP_OKAY), 32'(r.resp));
               check_hex("rlast", 32'h1, 32'(rlast));
               check_hex("rdata", shadow[idx] & mask, r.data & mask);
            end
            rd_pend = 1'b0;
         end
         if (bvalid && bready) begin
            if (aw_got && w_got) begin
               check_hex("bid", 32'(aw_id), 32'(b.id));
               check_hex("bresp", 32'(RESP_OKAY), 32'(b.resp));
               idx = word_of(aw_addr);
               // merge per byte strobe
               for (int i = 0; i < 4; i++) begin
                  if (w_strb[i]) begin
                     shadow[idx][8*i +: 8] = w_data[8*i +: 8];
                     known[idx][i] = 1'b1;
                  end
               end
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
         end
         // new captures last
         if (arvalid && arready) begin
            rd_pend  = 1'b1;
            rd_rose  = 1'b0;
            rd_edges = 0;
            rd_id    = ar.id;
            rd_addr  = ar.addr;
         end
         if (awvalid && awready) begin
            aw_got  = 1'b1;
            aw_id   = aw.id;
            aw_addr = aw.addr;
         end
         if (wvalid && wready) begin
            w_got  = 1'b1;
            w_data = w.data;
            w_strb = w.strb;
         end
      end
   end

endmodule

/* verif/axi_sram_tb.sv */
`timescale 1ns/100ps

module axi_sram_tb;

   import axi_sram_pkg::*;

   localparam int READ_LATENCY = 2;
   localparam int MEM_WORDS    = 1024;
   localparam int MAX_STALL    = 4;
   localparam int NUM_FIXED    = 16;
   localparam int NUM_RAND     = 8;
   localparam int NUM_ROWS     = NUM_FIXED + NUM_RAND;
   localparam int CLK_PERIOD   = 40;
   // whole-run budget in ns from the per-row cycle count
   localparam int WATCHDOG_NS  = NUM_ROWS * (READ_LATENCY + 2 + MAX_STALL + 8) * CLK_PERIOD;

   // row operations
   localparam logic [1:0] OP_WR    = 2'd0;
   localparam logic [1:0] OP_RD    = 2'd1;
   localparam logic [1:0] OP_WR_RD = 2'd2;
   // order of the aw and w beats
   localparam logic [1:0] ORD_AW   = 2'd0;
   localparam logic [1:0] ORD_W    = 2'd1;
   localparam logic [1:0] ORD_BOTH = 2'd2;

   // one stimulus row with stall in cycles of ready held low
   typedef struct packed {
      logic [1:0] op;
      addr_t      addr;
      data_t      data;
      strb_t      strb;
      id_t        id;
      logic [1:0] order;
      logic [2:0] stall;
   } row_t;

   logic        aclk;
   logic        reset;
   ar_req_t     ar;
   logic        arvalid;
   logic        arready;
   r_beat_t     r;
   logic        rlast;
   logic        rvalid;
   logic        rready;
   aw_req_t     aw;
   logic        awvalid;
   logic        awready;
   w_beat_t     w;
   logic        wlast;
   logic        wvalid;
   logic        wready;
   b_beat_t     b;
   logic        bvalid;
   logic        bready;
   int unsigned value_errors;
   int unsigned proto_errors;
   int unsigned assert_errors;
   row_t        rows[$];

   axi_sram_top #(
      .READ_LATENCY (READ_LATENCY),
      .MEM_WORDS    (MEM_WORDS)
   ) axi_sram_top_i (.*);

   axi_sram_monitor #(
      .READ_LATENCY (READ_LATENCY),
      .MEM_WORDS    (MEM_WORDS)
   ) monitor_i (.*);

   always #(CLK_PERIOD / 2) aclk = ~aclk;

   function automatic void add_row(logic [1:0] op, addr_t addr, data_t data, strb_t strb,
                                   id_t id, logic [1:0] order, int stall);
      rows.push_back('{op, addr, data, strb, id, order, 3'(stall)});
   endfunction

   // random rows stay inside 16 words aliased through the upper address bits
   function automatic void add_random_rows();
      addr_t word_off;
      addr_t alias_off;
      for (int i = 0; i < NUM_RAND; i++) begin
         word_off  = 32'(($urandom % 16) * 4);
         alias_off = 32'(($urandom % 4) * MEM_WORDS * 4);
         add_row(2'($urandom % 3), alias_off + word_off, $urandom, 4'($urandom),
                 5'($urandom), 2'($urandom % 3), int'($urandom % (MAX_STALL + 1)));
      end
   endfunction

   // entered and left on a falling edge
   task automatic do_write(row_t t);
      logic aw_hs;
      logic w_hs;
      aw      = '{id: t.id, addr: t.addr};
      // w id inverted so b can only match the aw id
      w       = '{id: ~t.id, data: t.data, strb: t.strb};
      awvalid = (t.order != ORD_W);
      wvalid  = (t.order != ORD_AW);
      while (awvalid || wvalid) begin
         @(posedge aclk);
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         @(negedge aclk);
         // second beat follows the first in the ordered cases
         if (aw_hs) begin
            awvalid = 1'b0;
            wvalid  = wvalid || (t.order == ORD_AW);
         end
         if (w_hs) begin
            wvalid  = 1'b0;
            awvalid = awvalid || (t.order == ORD_W);
         end
      end
      do @(posedge aclk); while (!bvalid);
      repeat (t.stall) @(posedge aclk);
      @(negedge aclk);
      bready = 1'b1;
      do @(posedge aclk); while (!bvalid);
      @(negedge aclk);
      bready = 1'b0;
   endtask

   task automatic do_read(row_t t);
      logic ar_hs;
      ar      = '{id: t.id, addr: t.addr};
      arvalid = 1'b1;
      do begin
         @(posedge aclk);
         ar_hs = arready;
         @(negedge aclk);
      end while (!ar_hs);
      arvalid = 1'b0;
      do @(posedge aclk); while (!rvalid);
      repeat (t.stall) @(posedge aclk);
      @(negedge aclk);
      rready = 1'b1;
      do @(posedge aclk); while (!rvalid);
      @(negedge aclk);
      rready = 1'b0;
   endtask

   initial begin
      void'($urandom(37368));
      aclk    = 1'b0;
      reset   = 1'b1;
      ar      = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      aw      = '0;
      awvalid = 1'b0;
      w       = '0;
      wlast   = 1'b1;
      wvalid  = 1'b0;
      bready  = 1'b0;
      // 0x1000 apart aliases to the same word
      add_row(OP_WR,    32'h0000_0010, 32'h1122_3344, 4'hf, 5'd1,  ORD_AW,   0);
      add_row(OP_RD,    32'h0000_0010, 32'h0,         4'h0, 5'd2,  ORD_AW,   0);
      add_row(OP_WR,    32'h0000_0010, 32'haabb_ccdd, 4'h5, 5'd3,  ORD_W,    2);
      add_row(OP_RD,    32'h0000_1010, 32'h0,         4'h0, 5'd4,  ORD_AW,   3);
      add_row(OP_WR,    32'h0000_0ffc, 32'hdead_beef, 4'hf, 5'd5,  ORD_BOTH, 0);
      add_row(OP_RD,    32'h0000_0ffc, 32'h0,         4'h0, 5'd6,  ORD_AW,   0);
      add_row(OP_WR_RD, 32'h0000_0020, 32'h0bad_f00d, 4'hf, 5'd7,  ORD_AW,   1);
      add_row(OP_WR,    32'h8000_2020, 32'h5566_7788, 4'h8, 5'd8,  ORD_BOTH, 4);
      add_row(OP_RD,    32'h0000_0020, 32'h0,         4'h0, 5'd9,  ORD_AW,   2);
      add_row(OP_WR_RD, 32'h0000_0100, 32'hcafe_babe, 4'h3, 5'd10, ORD_W,    0);
      add_row(OP_WR,    32'h0000_0104, 32'h0102_0304, 4'hf, 5'd31, ORD_AW,   3);
      add_row(OP_RD,    32'h0000_0104, 32'h0,         4'h0, 5'd0,  ORD_AW,   4);
      add_row(OP_WR,    32'h0000_0100, 32'hf0e0_d0c0, 4'hc, 5'd12, ORD_BOTH, 1);
      add_row(OP_RD,    32'h0000_0100, 32'h0,         4'h0, 5'd13, ORD_AW,   1);
      add_row(OP_RD,    32'h0000_4100, 32'h0,         4'h0, 5'd14, ORD_AW,   0);
      add_row(OP_WR_RD, 32'h0000_0ffc, 32'h1234_5678, 4'h6, 5'd15, ORD_W,    2);
      add_random_rows();
      repeat (2) @(posedge aclk);
      @(negedge aclk);
      reset = 1'b0;
      foreach (rows[i]) begin
         @(negedge aclk);
         case (rows[i].op)
            OP_WR: do_write(rows[i]);
            OP_RD: do_read(rows[i]);
            default: begin
               // read held off until the write's B retires
               fork
                  do_write(rows[i]);
                  do_read(rows[i]);
               join
            end
         endcase
      end
      repeat (4) @(negedge aclk);
      assert_errors = axi_sram_top_i.axi_sram_chk_i.fail_count;
      $display("errors: value %0d, protocol %0d, assertion %0d",
               value_errors, proto_errors, assert_errors);
      if (value_errors + proto_errors + assert_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("TIMEOUT: the run hung, no end reached after %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule
